/* hdl/img_pkg.sv */
package img_pkg;

    // =========================================================================
    // Sizes
    // =========================================================================
    localparam int WORD_W      = 16;
    localparam int PIX_W       = 12;
    localparam int HDR_W       = 128;
    localparam int HDR_WORDS   = HDR_W / WORD_W;
    localparam int BLOCK_WORDS = 1024;
    localparam int BLOCK_CNT   = 2;
    localparam int BLK_W       = $clog2(BLOCK_CNT);
    localparam int ADDR_W      = 10;
    // Pixel count must be able to hold a full block
    localparam int CNT_W       = 11;
    localparam int STAT_W      = 18;
    localparam int STAT_BITS   = 7;

    // Readout FIFO geometry
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_LVL_W  = $clog2(FIFO_DEPTH + 1);

    // =========================================================================
    // Bundles
    // =========================================================================
    typedef struct packed {
        logic [HDR_W-1:0] header;
        logic [BLK_W-1:0] block;
    } img_cmd_t;

    typedef struct packed {
        logic [CNT_W-1:0]  pixel_count;
        logic [STAT_W-1:0] highlight_count;
        logic [STAT_W-1:0] shadow_count;
    } cap_status_t;

    typedef struct packed {
        logic              en;
        logic [BLK_W-1:0]  block;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } store_wr_t;

    typedef struct packed {
        logic              en;
        logic [BLK_W-1:0]  block;
        logic [ADDR_W-1:0] addr;
    } store_rd_t;

endpackage

/* hdl/pixel_capture.sv */
module pixel_capture
    import img_pkg::*;
(
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  logic              capture_start,
    input  logic [PIX_W-1:0]  img_d,
    input  logic              img_fv,
    input  logic              img_lv,
    output logic              pix_valid,
    output logic [WORD_W-1:0] pix_data,
    output logic              frame_done,
    output cap_status_t       status
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_LOW,
        CAP_WAIT_HIGH,
        CAP_ACTIVE
    } cap_state_t;

    cap_state_t        state;
    logic [PIX_W-1:0]  d_q;
    logic              fv_q;
    logic              lv_q;
    logic              lv_prev;
    logic              armed;
    logic [1:0]        x_cnt;
    logic [1:0]        y_cnt;
    logic              stat_hit;
    logic [CNT_W-1:0]  pixel_count;
    logic [STAT_W-1:0] highlight_count;
    logic [STAT_W-1:0] shadow_count;

    // =========================================================================
    // Sensor input registers
    // =========================================================================
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            lv_prev <= lv_q;
        end
    end

    // Pixels count as soon as frame-valid rises, even before the state catches up
    assign armed     = ((state == CAP_ACTIVE) || (state == CAP_WAIT_HIGH)) && fv_q;
    assign pix_valid = armed && lv_q && (pixel_count < CNT_W'(BLOCK_WORDS));
    assign pix_data  = {{(WORD_W-PIX_W){1'b0}}, d_q};

    // =========================================================================
    // Frame sync FSM and counters
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state      <= CAP_IDLE;
            frame_done <= 1'b0;
            x_cnt      <= '0;
            y_cnt      <= '0;
        end else begin
            frame_done <= 1'b0;

            // Subsample position within the 4x4 grid
            if (!lv_q)
                x_cnt <= '0;
            else
                x_cnt <= x_cnt + 2'd1;
            if (!fv_q)
                y_cnt <= '0;
            else if (lv_prev && !lv_q)
                y_cnt <= y_cnt + 2'd1;

            case (state)
                CAP_IDLE: begin
                    if (capture_start)
                        state <= CAP_WAIT_LOW;
                end
                CAP_WAIT_LOW: begin
                    if (!fv_q)
                        state <= CAP_WAIT_HIGH;
                end
                CAP_WAIT_HIGH: begin
                    if (fv_q)
                        state <= CAP_ACTIVE;
                end
                CAP_ACTIVE: begin
                    if (!fv_q) begin
                        frame_done <= 1'b1;
                        state      <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    assign stat_hit = pix_valid && (x_cnt == 2'd0) && (y_cnt == 2'd0);

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (capture_start) begin
            // Header words sit in front of the pixels
            pixel_count     <= CNT_W'(HDR_WORDS);
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            if (pix_valid)
                pixel_count <= pixel_count + 1'b1;
            if (stat_hit) begin
                if (&d_q[PIX_W-1 -: STAT_BITS])
                    highlight_count <= highlight_count + 1'b1;
                else if (~|d_q[PIX_W-1 -: STAT_BITS])
                    shadow_count <= shadow_count + 1'b1;
            end
        end
    end

    always_comb begin
        status.pixel_count     = pixel_count;
        status.highlight_count = highlight_count;
        status.shadow_count    = shadow_count;
    end

    // Truncated frames never run the count past the block
    a_count_in_block: assert property (@(posedge clk) disable iff (!fifoIn_rst)
        pixel_count <= CNT_W'(BLOCK_WORDS));

endmodule

/* hdl/img_store.sv */
module img_store
    import img_pkg::*;
(
    input  logic              clk,
    input  store_wr_t         wr,
    input  store_rd_t         rd,
    output logic [WORD_W-1:0] rd_data
);

    // =========================================================================
    // Word array, one row per block
    // =========================================================================
    logic [WORD_W-1:0] mem [BLOCK_CNT][BLOCK_WORDS];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.block][wr.addr] <= wr.data;
    end

    // Registered read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.en)
            rd_data <= mem[rd.block][rd.addr];
    end

    // =========================================================================
    // Checks
    // =========================================================================
    a_wr_known: assert property (@(posedge clk)
        wr.en |-> !$isunknown({wr.block, wr.addr}));

    a_rd_known: assert property (@(posedge clk)
        rd.en |-> !$isunknown({rd.block, rd.addr}));

endmodule

/* hdl/readout_fifo.sv */
module readout_fifo
    import img_pkg::*;
(
    input  logic                  clk,
    input  logic                  fifoIn_rst,
    input  logic                  flush,
    input  logic                  push,
    input  logic [WORD_W-1:0]     push_data,
    output logic [FIFO_LVL_W-1:0] level,
    input  logic                  pop,
    output logic                  ready,
    output logic [WORD_W-1:0]     data
);

    logic [WORD_W-1:0]     buf_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;

    // Circular buffer storage
    always_ff @(posedge clk) begin
        if (push)
            buf_mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Head word falls through to the output
    assign ready = (level != '0);
    assign data  = buf_mem[rd_ptr];

    // =========================================================================
    // Checks
    // =========================================================================
    a_no_overflow: assert property (@(posedge clk) disable iff (!fifoIn_rst || flush)
        push && !pop |-> (level < FIFO_LVL_W'(FIFO_DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!fifoIn_rst || flush)
        pop |-> ready);

endmodule

/* hdl/img_ctrl.sv */
module img_ctrl
    import img_pkg::*;
(
    input  logic                  clk,
    input  logic                  fifoIn_rst,
    input  logic                  cmd_valid,
    input  img_cmd_t              cmd,
    output logic                  capture_start,
    input  logic                  pix_valid,
    input  logic [WORD_W-1:0]     pix_data,
    input  logic                  frame_done,
    input  logic [CNT_W-1:0]      pixel_count,
    output store_wr_t             wr,
    output store_rd_t             rd,
    input  logic [WORD_W-1:0]     rd_data,
    output logic                  fifo_push,
    output logic [WORD_W-1:0]     fifo_push_data,
    output logic                  fifo_flush,
    input  logic [FIFO_LVL_W-1:0] fifo_level,
    output logic                  capture_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_CAPTURE,
        ST_READOUT
    } ctrl_state_t;

    ctrl_state_t       state;
    logic [HDR_W-1:0]  hdr_q;
    logic [BLK_W-1:0]  block_q;
    logic [ADDR_W-1:0] wr_addr;
    logic [CNT_W-1:0]  readout_len;
    logic [CNT_W-1:0]  rd_cnt;
    logic [CNT_W-1:0]  push_cnt;
    logic              rd_vld;
    logic              credit_ok;
    logic              rd_issue;

    // =========================================================================
    // Readout credit
    // =========================================================================
    // A read in flight still needs a FIFO slot
    assign credit_ok = ({1'b0, fifo_level} + (FIFO_LVL_W+1)'(rd_vld))
                       < (FIFO_LVL_W+1)'(FIFO_DEPTH);

    // Skip the flush cycle so the level seen is the cleared one
    assign rd_issue = (state == ST_READOUT) && !fifo_flush
                      && (rd_cnt < readout_len) && credit_ok;

    assign fifo_push      = rd_vld;
    assign fifo_push_data = rd_data;

    // =========================================================================
    // Store ports
    // =========================================================================
    always_comb begin
        wr       = '0;
        wr.block = block_q;
        wr.addr  = wr_addr;
        if (state == ST_HEADER) begin
            wr.en   = 1'b1;
            wr.data = hdr_q[HDR_W-1 -: WORD_W];
        end else if (state == ST_CAPTURE) begin
            wr.en   = pix_valid;
            wr.data = pix_data;
        end
    end

    always_comb begin
        rd.en    = rd_issue;
        rd.block = block_q;
        rd.addr  = rd_cnt[ADDR_W-1:0];
    end

    // =========================================================================
    // Command latch and header shifter
    // =========================================================================
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) begin
            hdr_q   <= cmd.header;
            block_q <= cmd.block;
        end else if (state == ST_HEADER) begin
            hdr_q <= hdr_q << WORD_W;
        end
    end

    // =========================================================================
    // Main FSM
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state         <= ST_IDLE;
            capture_start <= 1'b0;
            capture_done  <= 1'b0;
            fifo_flush    <= 1'b0;
            rd_vld        <= 1'b0;
            wr_addr       <= '0;
            readout_len   <= '0;
            rd_cnt        <= '0;
            push_cnt      <= '0;
        end else begin
            capture_start <= 1'b0;
            capture_done  <= 1'b0;
            fifo_flush    <= 1'b0;
            rd_vld        <= rd_issue;

            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        wr_addr <= '0;
                        state   <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    // Address keeps counting into the pixel area
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == ADDR_W'(HDR_WORDS - 1)) begin
                        capture_start <= 1'b1;
                        state         <= ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    if (pix_valid)
                        wr_addr <= wr_addr + 1'b1;
                    if (frame_done) begin
                        readout_len  <= pixel_count;
                        capture_done <= 1'b1;
                        fifo_flush   <= 1'b1;
                        rd_cnt       <= '0;
                        push_cnt     <= '0;
                        state        <= ST_READOUT;
                    end
                end
                ST_READOUT: begin
                    if (rd_issue)
                        rd_cnt <= rd_cnt + 1'b1;
                    if (fifo_push)
                        push_cnt <= push_cnt + 1'b1;
                    if (push_cnt == readout_len)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* hdl/img_top.sv */
module img_top
    import img_pkg::*;
(
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  logic              cmd_valid,
    input  img_cmd_t          cmd,
    input  logic [PIX_W-1:0]  img_d,
    input  logic              img_fv,
    input  logic              img_lv,
    output cap_status_t       status,
    output logic              status_capture_done,
    output logic              readout_ready,
    input  logic              readout_trigger,
    output logic [WORD_W-1:0] readout_data
);

    logic                  capture_start;
    logic                  pix_valid;
    logic [WORD_W-1:0]     pix_data;
    logic                  frame_done;
    store_wr_t             store_wr;
    store_rd_t             store_rd;
    logic [WORD_W-1:0]     store_rd_data;
    logic                  fifo_push;
    logic [WORD_W-1:0]     fifo_push_data;
    logic                  fifo_flush;
    logic [FIFO_LVL_W-1:0] fifo_level;
    logic                  fifo_pop;

    // Transfer happens only when both sides agree
    assign fifo_pop = readout_trigger && readout_ready;

    img_ctrl ctrl_i (
        .clk            (clk),
        .fifoIn_rst     (fifoIn_rst),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .capture_start  (capture_start),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .frame_done     (frame_done),
        .pixel_count    (status.pixel_count),
        .wr             (store_wr),
        .rd             (store_rd),
        .rd_data        (store_rd_data),
        .fifo_push      (fifo_push),
        .fifo_push_data (fifo_push_data),
        .fifo_flush     (fifo_flush),
        .fifo_level     (fifo_level),
        .capture_done   (status_capture_done)
    );

    pixel_capture capture_i (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .capture_start (capture_start),
        .img_d         (img_d),
        .img_fv        (img_fv),
        .img_lv        (img_lv),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .frame_done    (frame_done),
        .status        (status)
    );

    img_store store_i (
        .clk     (clk),
        .wr      (store_wr),
        .rd      (store_rd),
        .rd_data (store_rd_data)
    );

    readout_fifo fifo_i (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .flush      (fifo_flush),
        .push       (fifo_push),
        .push_data  (fifo_push_data),
        .level      (fifo_level),
        .pop        (fifo_pop),
        .ready      (readout_ready),
        .data       (readout_data)
    );

endmodule

/* sim/tb_clkgen.sv */
module tb_clkgen (
    output logic clk,
    output logic fifoIn_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Active low reset held for the first cycles
    initial begin
        fifoIn_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        fifoIn_rst <= 1'b1;
    end

endmodule

/* sim/img_tb.sv */
module img_tb
    import img_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              fifoIn_rst;
    logic              cmd_valid;
    img_cmd_t          cmd;
    logic [PIX_W-1:0]  img_d;
    logic              img_fv;
    logic              img_lv;
    cap_status_t       status;
    logic              status_capture_done;
    logic              readout_ready;
    logic              readout_trigger;
    logic [WORD_W-1:0] readout_data;

    logic [31:0]       lcg_state = 32'h87e8;
    logic [PIX_W-1:0]  pix_ref [BLOCK_WORDS];
    logic [WORD_W-1:0] rx_words [BLOCK_WORDS];

    tb_clkgen clkgen_i (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst)
    );

    img_top dut_i (
        .clk                 (clk),
        .fifoIn_rst          (fifoIn_rst),
        .cmd_valid           (cmd_valid),
        .cmd                 (cmd),
        .img_d               (img_d),
        .img_fv              (img_fv),
        .img_lv              (img_lv),
        .status              (status),
        .status_capture_done (status_capture_done),
        .readout_ready       (readout_ready),
        .readout_trigger     (readout_trigger),
        .readout_data        (readout_data)
    );

    // =========================================================================
    // Helpers
    // =========================================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [HDR_W-1:0] random_header();
        return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    endfunction

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        fail_run();
    endtask

    task automatic fill_frame(input int w, input int h);
        for (int k = 0; k < w * h; k++)
            pix_ref[k] = PIX_W'(lcg_next() >> 8);
    endtask

    // =========================================================================
    // Host and sensor models
    // =========================================================================
    task automatic issue_cmd(input logic [HDR_W-1:0] hdr, input logic blk);
        @(posedge clk);
        cmd_valid  <= 1'b1;
        cmd.header <= hdr;
        cmd.block  <= blk;
        @(posedge clk);
        cmd_valid  <= 1'b0;
    endtask

    // Two idle cycles between lines and pixels from pix_ref in raster order
    task automatic drive_frame(input int w, input int h);
        @(posedge clk);
        img_fv <= 1'b1;
        repeat (2) @(posedge clk);
        for (int j = 0; j < h; j++) begin
            for (int i = 0; i < w; i++) begin
                @(posedge clk);
                img_lv <= 1'b1;
                img_d  <= pix_ref[j * w + i];
            end
            repeat (2) begin
                @(posedge clk);
                img_lv <= 1'b0;
            end
        end
        @(posedge clk);
        img_fv <= 1'b0;
    endtask

    task automatic wait_capture_done();
        int n = 0;
        @(negedge clk);
        while (!status_capture_done) begin
            n++;
            if (n > TIMEOUT)
                timeout_fail("status_capture_done");
            @(negedge clk);
        end
        @(negedge clk);
        check_value("status_capture_done", status_capture_done, 1'b0);
    endtask

    // A word moves on the edge after a negedge that sees trigger and ready high
    task automatic collect(input int n, input int gap);
        int count    = 0;
        int idle     = 0;
        int gap_left = 0;
        while (count < n) begin
            @(negedge clk);
            if (readout_trigger && readout_ready) begin
                rx_words[count] = readout_data;
                count++;
                gap_left = gap;
                idle     = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT)
                    timeout_fail("readout_ready");
            end
            @(posedge clk);
            if (count >= n || gap_left > 0) begin
                readout_trigger <= 1'b0;
                if (gap_left > 0)
                    gap_left--;
            end else begin
                readout_trigger <= 1'b1;
            end
        end
        // Nothing may be left once the expected words are out
        repeat (4) @(negedge clk);
        check_value("readout_ready", readout_ready, 1'b0);
    endtask

    // =========================================================================
    // Expected results
    // =========================================================================
    task automatic expected_stats(input int w, input int h, output int hl, output int sh);
        logic [STAT_BITS-1:0] top;
        hl = 0;
        sh = 0;
        for (int j = 0; j < h; j++) begin
            for (int i = 0; i < w; i++) begin
                top = pix_ref[j * w + i][PIX_W-1 -: STAT_BITS];
                if ((j * w + i) < (BLOCK_WORDS - HDR_WORDS) && (i % 4) == 0 && (j % 4) == 0) begin
                    if (top == '1)
                        hl++;
                    else if (top == '0)
                        sh++;
                end
            end
        end
    endtask

    task automatic check_status(input int w, input int h);
        int hl;
        int sh;
        expected_stats(w, h, hl, sh);
        check_value("status.pixel_count", status.pixel_count, HDR_WORDS + w * h);
        check_value("status.highlight_count", status.highlight_count, hl);
        check_value("status.shadow_count", status.shadow_count, sh);
    endtask

    task automatic check_readout(input logic [HDR_W-1:0] hdr, input int npix);
        for (int k = 0; k < HDR_WORDS; k++)
            check_value($sformatf("readout_data header %0d", k), rx_words[k],
                        WORD_W'(hdr >> (WORD_W * (HDR_WORDS - 1 - k))));
        for (int k = 0; k < npix; k++)
            check_value($sformatf("readout_data pixel %0d", k), rx_words[HDR_WORDS + k],
                        {4'h0, pix_ref[k]});
    endtask

    task automatic run_capture(input logic [HDR_W-1:0] hdr, input logic blk,
                               input int w, input int h, input int gap);
        issue_cmd(hdr, blk);
        repeat (20) @(posedge clk);
        drive_frame(w, h);
        wait_capture_done();
        check_status(w, h);
        collect(HDR_WORDS + w * h, gap);
        check_readout(hdr, w * h);
    endtask

    task automatic wait_reset_release();
        int n = 0;
        while (fifoIn_rst !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                timeout_fail("reset release");
        end
        @(posedge clk);
    endtask

    // =========================================================================
    // Tests
    // =========================================================================
    task automatic test_reset_values();
        @(negedge clk);
        check_value("readout_ready", readout_ready, 1'b0);
        check_value("status_capture_done", status_capture_done, 1'b0);
        check_value("status.pixel_count", status.pixel_count, 0);
        check_value("status.highlight_count", status.highlight_count, 0);
        check_value("status.shadow_count", status.shadow_count, 0);
    endtask

    task automatic test_stats_grid();
        fill_frame(12, 9);
        // Planted pixels on and beside the 4x4 subsample grid
        pix_ref[0 * 12 + 0] = 12'hFE5;
        pix_ref[0 * 12 + 4] = 12'h01A;
        pix_ref[4 * 12 + 8] = 12'hFFF;
        pix_ref[8 * 12 + 0] = 12'h000;
        pix_ref[8 * 12 + 4] = 12'hFC0;
        pix_ref[0 * 12 + 1] = 12'hFFF;
        pix_ref[1 * 12 + 0] = 12'h000;
        pix_ref[4 * 12 + 5] = 12'h010;
        run_capture(random_header(), 1'b0, 12, 9, 0);
    endtask

    task automatic test_mid_frame();
        logic [HDR_W-1:0] hdr;
        hdr = random_header();
        fill_frame(8, 8);
        // Command lands while the first frame is already running
        fork
            drive_frame(8, 8);
            begin
                repeat (6) @(posedge clk);
                issue_cmd(hdr, 1'b0);
            end
        join
        fill_frame(8, 8);
        repeat (6) @(posedge clk);
        drive_frame(8, 8);
        wait_capture_done();
        check_status(8, 8);
        collect(HDR_WORDS + 64, 0);
        check_readout(hdr, 64);
    endtask

    initial begin
        cmd_valid       = 1'b0;
        cmd             = '0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        wait_reset_release();

        test_reset_values();

        // Frame without any line
        run_capture(random_header(), 1'b0, 0, 0, 0);

        fill_frame(8, 8);
        run_capture(random_header(), 1'b1, 8, 8, 0);

        test_stats_grid();

        // Slow host fills the FIFO
        fill_frame(16, 10);
        run_capture(random_header(), 1'b1, 16, 10, 4);

        test_mid_frame();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* sim.f */
hdl/img_pkg.sv
hdl/pixel_capture.sv
hdl/img_store.sv
hdl/readout_fifo.sv
hdl/img_ctrl.sv
hdl/img_top.sv
sim/tb_clkgen.sv
sim/img_tb.sv
